// ==== filelist.f ====
src/offload_pkg.sv
src/offload_demux.sv
src/ssr_cfg_unit.sv
src/resp_arbiter.sv
src/offload_complex.sv
bench/tb_clkgen.sv
bench/offload_complex_chk.sv
bench/tb_offload_complex.sv

// ==== bench/tb_offload_complex.sv ====
/*
 * Offload complex testbench
 * Directed tests with external port models and a response scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

module tb_offload_complex;

  import offload_pkg::*;

  logic                     clk_i;
  logic                     rst_ni;
  acc_req_t                 acc_req_i;
  logic                     acc_qvalid_i;
  logic                     acc_qready_o;
  acc_rsp_t                 acc_rsp_o;
  logic                     acc_pvalid_o;
  logic                     acc_pready_i;
  acc_req_t                 ext_req_o;
  logic [NumExt-1:0]        ext_qvalid_o;
  logic [NumExt-1:0]        ext_qready_i;
  acc_rsp_t [NumExt-1:0]    ext_rsp_i;
  logic [NumExt-1:0]        ext_pvalid_i;
  logic [NumExt-1:0]        ext_pready_o;

  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycles = 0;
  acc_rsp_t    exp_q [NumTargets][$];
  acc_rsp_t    pend_q [NumExt][$];
  logic [DataW-1:0] ssr_model [NumSsrs][NumCfgRegs];

  tb_clkgen u_clkgen (.clk_o(clk_i), .rst_o(rst_ni));

  offload_complex u_offload_complex (.*);

  function automatic int unsigned port_of(input logic [TgtAddrW-1:0] a);
    return (a == TgtSnax) ? 2 : int'(a);
  endfunction

  // Reference model of the SSR config registers
  function automatic acc_rsp_t ssr_expect(input acc_req_t r);
    logic [2:0]  f3;
    logic [11:0] a;
    logic        wr;
    logic        ok;
    acc_rsp_t    e;
    f3 = r.data_op[14:12];
    a  = (f3 == F3Scfgri || f3 == F3Scfgwi) ? r.data_op[31:20] : r.data_argb[11:0];
    wr = (f3 == F3Scfgwi || f3 == F3Scfgw);
    ok = (a[4:0] < NumSsrs) && (a[11:5] < NumCfgRegs);
    e.error = 1'b0;
    e.id    = wr ? '0 : r.id;
    e.data  = ok ? ssr_model[a[4:0]][a[11:5]] : '0;
    if (wr && ok) ssr_model[a[4:0]][a[11:5]] = r.data_arga;
    return e;
  endfunction

  function automatic acc_req_t mk_req(input logic [1:0] addr, input logic [4:0] id,
                                      input logic [2:0] f3, input logic [11:0] imm,
                                      input logic [31:0] a, input logic [31:0] b);
    acc_req_t r;
    r.addr      = addr;
    r.id        = id;
    r.data_op   = {imm, 5'd0, f3, 5'd0, OpcScfg};
    r.data_arga = a;
    r.data_argb = b;
    return r;
  endfunction

  function automatic int unsigned pending();
    int unsigned n;
    n = 0;
    for (int s = 0; s < NumTargets; s++) n += exp_q[s].size();
    return n;
  endfunction

  // Each source must deliver in order, so only queue heads may match
  task automatic check_response(input acc_rsp_t got);
    acc_rsp_t first;
    logic     found;
    found = 1'b0;
    first = 'x;
    checks++;
    for (int s = 0; s < NumTargets; s++) begin
      if (!found && exp_q[s].size() != 0) begin
        if (first === 'x) first = exp_q[s][0];
        if (exp_q[s][0] == got) begin
          found = 1'b1;
          void'(exp_q[s].pop_front());
        end
      end
    end
    if (!found) begin
      errors++;
      $display("mismatch at %0t: acc_rsp_o got %h expected %h", $time, got, first);
    end
  endtask

  task automatic expect_idle();
    checks++;
    if (acc_pvalid_o !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: acc_pvalid_o got %b expected 0", $time, acc_pvalid_o);
    end
    if (ext_qvalid_o !== '0) begin
      errors++;
      $display("mismatch at %0t: ext_qvalid_o got %b expected 0", $time, ext_qvalid_o);
    end
    if (ext_pready_o !== '0) begin
      errors++;
      $display("mismatch at %0t: ext_pready_o got %b expected 0", $time, ext_pready_o);
    end
  endtask

  // --------------------------------------------------
  // External port models and response monitor
  // --------------------------------------------------
  always @(posedge clk_i) begin
    for (int p = 0; p < NumExt; p++) begin
      if (ext_pvalid_i[p] && ext_pready_o[p]) void'(pend_q[p].pop_front());
      if (ext_qvalid_o[p] && ext_qready_i[p]) begin
        pend_q[p].push_back(acc_rsp_t'{ext_req_o.id, ext_req_o.data_arga + DataW'(p), 1'b0});
      end
    end
    if (acc_pvalid_o && acc_pready_i) check_response(acc_rsp_o);
    #1;
    for (int p = 0; p < NumExt; p++) begin
      ext_qready_i[p] = $urandom_range(0, 1);
      ext_pvalid_i[p] = (pend_q[p].size() != 0);
      ext_rsp_i[p]    = (pend_q[p].size() != 0) ? pend_q[p][0] : '0;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 2000) begin
      $display("timeout after %0d cycles, %0d responses outstanding", cycles, pending());
      $display("Done: errors found");
      $finish;
    end
  end

  // Holds the request until taken and checks routing every cycle
  task automatic send_req(input acc_req_t r);
    logic [NumExt-1:0] want;
    want = (r.addr == TgtSsr) ? '0 : NumExt'(1 << port_of(r.addr));
    acc_req_i    = r;
    acc_qvalid_i = 1'b1;
    forever begin
      @(posedge clk_i);
      checks++;
      if (ext_qvalid_o !== want) begin
        errors++;
        $display("mismatch at %0t: ext_qvalid_o got %b expected %b", $time, ext_qvalid_o, want);
      end
      if (r.addr != TgtSsr && ext_req_o !== r) begin
        errors++;
        $display("mismatch at %0t: ext_req_o got %h expected %h", $time, ext_req_o, r);
      end
      if (acc_qready_o) break;
    end
    if (r.addr == TgtSsr) exp_q[TgtSsr].push_back(ssr_expect(r));
    else exp_q[r.addr].push_back(acc_rsp_t'{r.id, r.data_arga + DataW'(port_of(r.addr)), 1'b0});
    #1 acc_qvalid_i = 1'b0;
  endtask

  // Polls just after the edge, once the monitor has seen it
  task automatic wait_drain();
    while (pending() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic reset_idle();
    repeat (3) @(posedge clk_i);
    expect_idle();
    wait (!rst_ni);
    @(posedge clk_i);
    expect_idle();
    #1;
  endtask

  task automatic route_requests();
    send_req(mk_req(TgtFpu, 5'd1, 3'd0, 12'd0, 32'h100, 32'd0));
    send_req(mk_req(TgtShared, 5'd2, 3'd0, 12'd0, 32'h200, 32'd0));
    send_req(mk_req(TgtSnax, 5'd3, 3'd0, 12'd0, 32'h300, 32'd0));
    wait_drain();
  endtask

  // Write then read, immediate form on SSR 1 and register form on SSR 0
  task automatic write_then_read();
    int unsigned n;
    send_req(mk_req(TgtSsr, 5'd4, F3Scfgwi, {7'd3, 5'd1}, 32'hcafe_0001, 32'd0));
    wait_drain();
    send_req(mk_req(TgtSsr, 5'd5, F3Scfgri, {7'd3, 5'd1}, 32'd0, 32'd0));
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!acc_pvalid_o && n < 10);
    checks++;
    if (n != 2) begin
      errors++;
      $display("mismatch at %0t: read latency got %0d expected 2", $time, n);
    end
    #1;
    send_req(mk_req(TgtSsr, 5'd6, F3Scfgw, 12'd0, 32'hbeef_0002, {20'd0, 7'd5, 5'd0}));
    send_req(mk_req(TgtSsr, 5'd7, F3Scfgr, 12'd0, 32'd0, {20'd0, 7'd5, 5'd0}));
    wait_drain();
  endtask

  task automatic out_of_range_access();
    send_req(mk_req(TgtSsr, 5'd8, F3Scfgwi, {7'd0, 5'd2}, 32'hdead_0003, 32'd0));
    send_req(mk_req(TgtSsr, 5'd9, F3Scfgwi, {7'd8, 5'd0}, 32'hdead_0004, 32'd0));
    send_req(mk_req(TgtSsr, 5'd10, F3Scfgri, {7'd0, 5'd2}, 32'd0, 32'd0));
    send_req(mk_req(TgtSsr, 5'd11, F3Scfgri, {7'd8, 5'd0}, 32'd0, 32'd0));
    for (int s = 0; s < NumSsrs; s++) begin
      for (int g = 0; g < NumCfgRegs; g++) begin
        send_req(mk_req(TgtSsr, 5'(g + 12), F3Scfgri, {7'(g), 5'(s)}, 32'd0, 32'd0));
      end
    end
    wait_drain();
  endtask

  task automatic merge_responses();
    logic [2:0] f3;
    for (int i = 0; i < 16; i++) begin
      // Core stalls while one request per target goes out
      if (i % 4 == 0) acc_pready_i = 1'b0;
      f3 = (i % 8 == 2) ? F3Scfgwi : F3Scfgri;
      send_req(mk_req(2'(i), 5'(i + 1), f3, {7'(i % 8), 5'(i % 2)}, $urandom, 32'd0));
      if (i % 4 == 3) begin
        acc_pready_i = 1'b1;
        wait_drain();
      end
    end
  endtask

  task automatic stall_responses();
    acc_rsp_t held;
    acc_pready_i = 1'b0;
    send_req(mk_req(TgtFpu, 5'd20, 3'd0, 12'd0, 32'h11, 32'd0));
    send_req(mk_req(TgtShared, 5'd21, 3'd0, 12'd0, 32'h22, 32'd0));
    send_req(mk_req(TgtSsr, 5'd22, F3Scfgri, {7'd3, 5'd1}, 32'd0, 32'd0));
    send_req(mk_req(TgtSnax, 5'd23, 3'd0, 12'd0, 32'h33, 32'd0));
    while (!acc_pvalid_o) @(posedge clk_i);
    @(posedge clk_i);
    held = acc_rsp_o;
    repeat (6) begin
      @(posedge clk_i);
      checks++;
      if (!acc_pvalid_o || acc_rsp_o !== held) begin
        errors++;
        $display("mismatch at %0t: acc_rsp_o got %h expected %h", $time, acc_rsp_o, held);
      end
    end
    #1 acc_pready_i = 1'b1;
    wait_drain();
  endtask

  initial begin
    void'($urandom(21));
    for (int s = 0; s < NumSsrs; s++) begin
      for (int g = 0; g < NumCfgRegs; g++) ssr_model[s][g] = '0;
    end
    acc_req_i    = '0;
    acc_qvalid_i = 1'b0;
    acc_pready_i = 1'b1;
    ext_qready_i = '0;
    ext_rsp_i    = '0;
    ext_pvalid_i = '0;
    reset_idle();
    route_requests();
    write_then_read();
    out_of_range_access();
    merge_responses();
    stall_responses();
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/offload_complex_chk.sv ====
/*
 * Offload complex assertions
 * Handshake and reset properties on the top-level ports
 */
`timescale 1ns/1ps
`default_nettype none

module offload_complex_chk (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input offload_pkg::acc_rsp_t                 acc_rsp_o,
  input logic                                  acc_pvalid_o,
  input logic                                  acc_pready_i,
  input logic [offload_pkg::NumExt-1:0]        ext_qvalid_o
);

  // Stalled response holds its payload
  rsp_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_pvalid_o && !acc_pready_i |=> acc_pvalid_o && $stable(acc_rsp_o))
    else $error("acc_rsp_o changed under back-pressure");

  ext_onehot: assert property (@(posedge clk_i) $onehot0(ext_qvalid_o))
    else $error("ext_qvalid_o not one-hot");

  ext_idle_rst: assert property (@(posedge clk_i) rst_ni |-> ext_qvalid_o == '0)
    else $error("ext_qvalid_o high in reset");

  pvalid_after_rst: assert property (@(posedge clk_i) rst_ni |=> !acc_pvalid_o)
    else $error("acc_pvalid_o high after reset cycle");

endmodule

bind offload_complex offload_complex_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .acc_rsp_o    (acc_rsp_o),
  .acc_pvalid_o (acc_pvalid_o),
  .acc_pready_i (acc_pready_i),
  .ext_qvalid_o (ext_qvalid_o)
);

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
/*
 * Testbench clock and reset
 * 4 ns clock, reset held high for the first 8 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release just after an edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== src/offload_complex.sv ====
/*
 * Offload complex
 * Steers core offload requests to the FPU, shared muldiv, SSR config
 * and SNAX targets and merges their responses back to the core
 */
`timescale 1ns/1ps
`default_nettype none

module offload_complex (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  offload_pkg::acc_req_t                           acc_req_i,
  input  logic                                            acc_qvalid_i,
  output logic                                            acc_qready_o,
  output offload_pkg::acc_rsp_t                           acc_rsp_o,
  output logic                                            acc_pvalid_o,
  input  logic                                            acc_pready_i,
  output offload_pkg::acc_req_t                           ext_req_o,
  output logic [offload_pkg::NumExt-1:0]                  ext_qvalid_o,
  input  logic [offload_pkg::NumExt-1:0]                  ext_qready_i,
  input  offload_pkg::acc_rsp_t [offload_pkg::NumExt-1:0] ext_rsp_i,
  input  logic [offload_pkg::NumExt-1:0]                  ext_pvalid_i,
  output logic [offload_pkg::NumExt-1:0]                  ext_pready_o
);

  import offload_pkg::*;

  logic [NumTargets-1:0]     tgt_qvalid;
  logic [NumTargets-1:0]     tgt_qready;
  acc_rsp_t [NumTargets-1:0] tgt_rsp;
  logic [NumTargets-1:0]     tgt_pvalid;
  logic [NumTargets-1:0]     tgt_pready;

  logic     ssr_qready;
  acc_rsp_t ssr_rsp;
  logic     ssr_pvalid;

  offload_demux u_demux (
    .acc_req_i    (acc_req_i),
    .acc_qvalid_i (acc_qvalid_i),
    .acc_qready_o (acc_qready_o),
    .tgt_qvalid_o (tgt_qvalid),
    .tgt_qready_i (tgt_qready)
  );

  // --------------------------------------------------
  // Target map, ext ports 0/1/2 are FPU/shared/SNAX
  // --------------------------------------------------
  // Request payload fans out to every external port
  assign ext_req_o    = acc_req_i;
  assign ext_qvalid_o = {tgt_qvalid[TgtSnax], tgt_qvalid[TgtShared], tgt_qvalid[TgtFpu]};
  assign ext_pready_o = {tgt_pready[TgtSnax], tgt_pready[TgtShared], tgt_pready[TgtFpu]};

  always_comb begin
    tgt_qready[TgtFpu]    = ext_qready_i[0];
    tgt_qready[TgtShared] = ext_qready_i[1];
    tgt_qready[TgtSsr]    = ssr_qready;
    tgt_qready[TgtSnax]   = ext_qready_i[2];
    tgt_rsp[TgtFpu]       = ext_rsp_i[0];
    tgt_rsp[TgtShared]    = ext_rsp_i[1];
    tgt_rsp[TgtSsr]       = ssr_rsp;
    tgt_rsp[TgtSnax]      = ext_rsp_i[2];
    tgt_pvalid[TgtFpu]    = ext_pvalid_i[0];
    tgt_pvalid[TgtShared] = ext_pvalid_i[1];
    tgt_pvalid[TgtSsr]    = ssr_pvalid;
    tgt_pvalid[TgtSnax]   = ext_pvalid_i[2];
  end

  ssr_cfg_unit u_ssr_cfg (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (acc_req_i),
    .qvalid_i (tgt_qvalid[TgtSsr]),
    .qready_o (ssr_qready),
    .rsp_o    (ssr_rsp),
    .pvalid_o (ssr_pvalid),
    .pready_i (tgt_pready[TgtSsr])
  );

  resp_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .inp_rsp_i    (tgt_rsp),
    .inp_pvalid_i (tgt_pvalid),
    .inp_pready_o (tgt_pready),
    .oup_rsp_o    (acc_rsp_o),
    .oup_pvalid_o (acc_pvalid_o),
    .oup_pready_i (acc_pready_i)
  );

endmodule

`default_nettype wire

// ==== src/resp_arbiter.sv ====
/*
 * Response arbiter
 * Round-robin merge of the target responses into one registered
 * response stream back to the core
 */
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  offload_pkg::acc_rsp_t [offload_pkg::NumTargets-1:0] inp_rsp_i,
  input  logic [offload_pkg::NumTargets-1:0]                  inp_pvalid_i,
  output logic [offload_pkg::NumTargets-1:0]                  inp_pready_o,
  output offload_pkg::acc_rsp_t                               oup_rsp_o,
  output logic                                                oup_pvalid_o,
  input  logic                                                oup_pready_i
);

  import offload_pkg::*;

  logic [TgtAddrW-1:0] last_q;
  logic [TgtAddrW-1:0] win;
  logic                any_valid;
  logic                take;
  int unsigned         cand;

  acc_rsp_t oup_rsp_q;
  logic     oup_pvalid_q;

  // Output slot takes a new entry when empty or drained
  assign take = ~oup_pvalid_q | oup_pready_i;

  // --------------------------------------------------
  // Round-robin pick
  // --------------------------------------------------
  // Search starts just after the last winner and wraps
  always_comb begin
    win       = last_q;
    any_valid = 1'b0;
    cand      = 0;
    for (int unsigned i = 1; i <= NumTargets; i++) begin
      cand = (last_q + i) % NumTargets;
      if (!any_valid && inp_pvalid_i[cand]) begin
        any_valid = 1'b1;
        win       = cand[TgtAddrW-1:0];
      end
    end
  end

  always_comb begin
    inp_pready_o = '0;
    if (take && any_valid) begin
      inp_pready_o[win] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      oup_pvalid_q <= 1'b0;
      last_q       <= TgtAddrW'(NumTargets - 1);
    end else if (take) begin
      oup_pvalid_q <= any_valid;
      if (any_valid) begin
        last_q <= win;
      end
    end
  end

  // Payload held while the core stalls
  always_ff @(posedge clk_i) begin
    if (take && any_valid) begin
      oup_rsp_q <= inp_rsp_i[win];
    end
  end

  assign oup_rsp_o    = oup_rsp_q;
  assign oup_pvalid_o = oup_pvalid_q;

endmodule

`default_nettype wire

// ==== src/ssr_cfg_unit.sv ====
/*
 * SSR configuration unit
 * Decodes the scfg read and write instructions and serves them from a
 * per-SSR config register file, one response slot deep
 */
`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  offload_pkg::acc_req_t req_i,
  input  logic                  qvalid_i,
  output logic                  qready_o,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  pvalid_o,
  input  logic                  pready_i
);

  import offload_pkg::*;

  logic [NumSsrs-1:0][NumCfgRegs-1:0][DataW-1:0] regs_q;

  logic [CfgAddrW-1:0] cfg_addr;
  cfg_word_t           word;
  logic                is_imm;
  logic                is_reg;
  logic                is_write;
  logic                in_range;
  logic [DataW-1:0]    rdata;
  logic                accept;

  acc_rsp_t rsp_q;
  logic     pvalid_q;
  logic     live_q;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign is_imm = (req_i.data_op.itype.opcode == OpcScfg) &&
                  ((req_i.data_op.itype.funct3 == F3Scfgri) ||
                   (req_i.data_op.itype.funct3 == F3Scfgwi));
  assign is_reg = (req_i.data_op.rtype.opcode == OpcScfg) &&
                  ((req_i.data_op.rtype.funct3 == F3Scfgr) ||
                   (req_i.data_op.rtype.funct3 == F3Scfgw));

  // Unknown ops fall through as a read of SSR 0, register 0
  always_comb begin
    cfg_addr = '0;
    is_write = 1'b0;
    if (is_imm) begin
      cfg_addr = req_i.data_op.itype.imm12;
      is_write = (req_i.data_op.itype.funct3 == F3Scfgwi);
    end else if (is_reg) begin
      cfg_addr = req_i.data_argb[CfgAddrW-1:0];
      is_write = (req_i.data_op.rtype.funct3 == F3Scfgw);
    end
    word.reg_idx = cfg_addr[11:5];
    word.dm      = cfg_addr[4:0];
  end

  assign in_range = (word.dm < NumSsrs) && (word.reg_idx < NumCfgRegs);

  // Holes in the address space read as zero
  assign rdata = in_range ? regs_q[word.dm[SsrSelW-1:0]][word.reg_idx[CfgSelW-1:0]] : '0;

  // --------------------------------------------------
  // Handshake and register file
  // --------------------------------------------------
  // Slot frees up when empty or drained this cycle
  assign qready_o = live_q & (~pvalid_q | pready_i);
  assign accept   = qvalid_i & qready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      live_q   <= 1'b0;
      pvalid_q <= 1'b0;
      regs_q   <= '0;
    end else begin
      live_q <= 1'b1;
      if (accept) begin
        pvalid_q <= 1'b1;
        if (is_write && in_range) begin
          regs_q[word.dm[SsrSelW-1:0]][word.reg_idx[CfgSelW-1:0]] <= req_i.data_arga;
        end
      end else if (pready_i) begin
        pvalid_q <= 1'b0;
      end
    end
  end

  // Writes answer with id 0 so the core writes nothing back
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.id    <= is_write ? '0 : req_i.id;
      rsp_q.data  <= rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o    = rsp_q;
  assign pvalid_o = pvalid_q;

endmodule

`default_nettype wire

// ==== src/offload_demux.sv ====
/*
 * Offload request demux
 * Raises valid on the target picked by the request address and
 * hands that target's ready back to the core
 */
`timescale 1ns/1ps
`default_nettype none

module offload_demux (
  input  offload_pkg::acc_req_t              acc_req_i,
  input  logic                               acc_qvalid_i,
  output logic                               acc_qready_o,
  output logic [offload_pkg::NumTargets-1:0] tgt_qvalid_o,
  input  logic [offload_pkg::NumTargets-1:0] tgt_qready_i
);

  import offload_pkg::*;

  // One-hot valid, at most one target sees the request
  always_comb begin
    tgt_qvalid_o = '0;
    for (int unsigned i = 0; i < NumTargets; i++) begin
      if (acc_req_i.addr == TgtAddrW'(i)) begin
        tgt_qvalid_o[i] = acc_qvalid_i;
      end
    end
  end

  // Ready follows the addressed target only
  always_comb begin
    acc_qready_o = 1'b0;
    for (int unsigned i = 0; i < NumTargets; i++) begin
      if (acc_req_i.addr == TgtAddrW'(i)) begin
        acc_qready_o = tgt_qready_i[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/offload_pkg.sv ====
/*
 * Offload path definitions
 * Widths, target codes, SSR configuration opcodes and the request,
 * response and instruction-word types shared by the offload complex
 */
`default_nettype none

package offload_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned NumTargets = 4;
  localparam int unsigned NumExt     = 3;
  localparam int unsigned TgtAddrW   = 2;
  localparam int unsigned IdW        = 5;
  localparam int unsigned DataW      = 32;
  localparam int unsigned NumSsrs    = 2;
  localparam int unsigned NumCfgRegs = 8;

  // Index widths into the SSR config register file
  localparam int unsigned SsrSelW  = $clog2(NumSsrs);
  localparam int unsigned CfgSelW  = $clog2(NumCfgRegs);
  localparam int unsigned CfgAddrW = 12;

  // Target codes on the addr field
  localparam logic [TgtAddrW-1:0] TgtFpu    = 2'd0;
  localparam logic [TgtAddrW-1:0] TgtShared = 2'd1;
  localparam logic [TgtAddrW-1:0] TgtSsr    = 2'd2;
  localparam logic [TgtAddrW-1:0] TgtSnax   = 2'd3;

  // SSR config instructions, one custom opcode and four funct3 codes
  localparam logic [6:0] OpcScfg  = 7'b0101011;
  localparam logic [2:0] F3Scfgri = 3'b001;
  localparam logic [2:0] F3Scfgwi = 3'b010;
  localparam logic [2:0] F3Scfgr  = 3'b011;
  localparam logic [2:0] F3Scfgw  = 3'b100;

  // --------------------------------------------------
  // Instruction word views
  // --------------------------------------------------
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } scfg_itype_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } scfg_rtype_t;

  typedef union packed {
    scfg_itype_t itype;
    scfg_rtype_t rtype;
  } scfg_insn_u;

  // --------------------------------------------------
  // Offload request and response
  // --------------------------------------------------
  typedef struct packed {
    logic [TgtAddrW-1:0] addr;
    logic [IdW-1:0]      id;
    scfg_insn_u          data_op;
    logic [DataW-1:0]    data_arga;
    logic [DataW-1:0]    data_argb;
  } acc_req_t;

  typedef struct packed {
    logic [IdW-1:0]   id;
    logic [DataW-1:0] data;
    logic             error;
  } acc_rsp_t;

  // SSR select and register index of one config access
  typedef struct packed {
    logic [4:0] dm;
    logic [6:0] reg_idx;
  } cfg_word_t;

endpackage

`default_nettype wire
